// File: cache_cfg.svh
// All sizes must be powers of two; word width a multiple of 8 and at least two MSHR entries
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// ------------------------------------------------------------------------
// Address and data widths
// ------------------------------------------------------------------------
// Byte address width
`define CC_ADDR_W       16
// One processor word
`define CC_WORD_W       32
// Words per cache block
`define CC_BLOCK_WORDS  4

// ------------------------------------------------------------------------
// Storage and tracking
// ------------------------------------------------------------------------
// Direct-mapped lines
`define CC_LINES        16
// Outstanding miss entries
`define CC_MSHR_NUM     4
// Requester tag from processor
`define CC_TAG_W        4

`endif

// File: cache_ctrl.sv
// Loads only, direct-mapped; memory must echo id and block address and answer each request once
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cache_ctrl
    import cache_pkg::*;
    import mshr_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    // Processor side
    input  logic      proc_req_i,
    input  addr_t     proc_addr_i,
    input  req_tag_t  proc_tag_i,
    output logic      mshr_full_o,
    output logic      proc_rsp_o,
    output req_tag_t  proc_rsp_tag_o,
    output word_t     proc_rsp_data_o,
    // Memory side
    output logic      mem_req_o,
    output addr_t     mem_addr_o,
    output mshr_idx_t mem_id_o,
    input  logic      mem_enable_i,
    input  logic      mem_rsp_i,
    input  mshr_idx_t mem_rsp_id_i,
    input  addr_t     mem_rsp_addr_i,
    input  block_t    mem_rsp_data_i
);

    localparam int N = `CC_MSHR_NUM;

    // Lookup and storage
    addr_t       cm_addr;
    logic        cm_hit;
    word_t       cm_word;

    // Entry status and allocation
    mshr_state_e ent_state [N];
    blk_addr_t   ent_blk   [N];
    logic [N-1:0] alloc;
    addr_t       req_addr;
    req_tag_t    req_tag;
    logic        dep;
    mshr_idx_t   dep_idx;
    logic [N-1:0] cp_flag;

    // Memory switch, entries only
    logic [N-1:0] mem_req;
    logic [N-1:0] mem_grant;
    mem_req_t    mem_pl [N];
    mem_req_t    mem_out;

    // Response switch, bit 0 is the hit path
    logic [N:0]  rsp_req;
    logic [N:0]  rsp_grant;
    proc_rsp_t   rsp_pl [N+1];
    proc_rsp_t   rsp_out;

    // ------------------------------------------------------------------------
    // Stage 1, lookup and tag storage
    // ------------------------------------------------------------------------
    cache_lookup u_lookup (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .proc_req_i    (proc_req_i),
        .proc_addr_i   (proc_addr_i),
        .proc_tag_i    (proc_tag_i),
        .cm_addr_o     (cm_addr),
        .cm_hit_i      (cm_hit),
        .cm_word_i     (cm_word),
        .mshr_state_i  (ent_state),
        .mshr_blk_i    (ent_blk),
        .alloc_o       (alloc),
        .req_addr_o    (req_addr),
        .req_tag_o     (req_tag),
        .dep_o         (dep),
        .dep_idx_o     (dep_idx),
        .hit_rsp_o     (rsp_req[0]),
        .hit_payload_o (rsp_pl[0]),
        .mshr_full_o   (mshr_full_o)
    );

    // Filled straight from the memory response
    cache_mem u_mem (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .rd_addr_i   (cm_addr),
        .rd_hit_o    (cm_hit),
        .rd_word_o   (cm_word),
        .fill_i      (mem_rsp_i),
        .fill_addr_i (mem_rsp_addr_i),
        .fill_data_i (mem_rsp_data_i)
    );

    // ------------------------------------------------------------------------
    // Stage 2, MSHR entries
    // ------------------------------------------------------------------------
    for (genvar g = 0; g < N; g++) begin : g_entry
        mshr_entry #(
            .ENTRY_IDX (mshr_idx_t'(g))
        ) u_entry (
            .clk_i          (clk_i),
            .reset_i        (reset_i),
            .alloc_i        (alloc[g]),
            .req_addr_i     (req_addr),
            .req_tag_i      (req_tag),
            .dep_i          (dep),
            .dep_idx_i      (dep_idx),
            .state_o        (ent_state[g]),
            .blk_o          (ent_blk[g]),
            .mem_grant_i    (mem_grant[g]),
            .mem_req_o      (mem_req[g]),
            .mem_payload_o  (mem_pl[g]),
            .mem_rsp_i      (mem_rsp_i),
            .mem_rsp_id_i   (mem_rsp_id_i),
            .mem_rsp_data_i (mem_rsp_data_i),
            .cp_flag_o      (cp_flag[g]),
            .cp_flags_i     (cp_flag),
            .rsp_grant_i    (rsp_grant[g+1]),
            .rsp_req_o      (rsp_req[g+1]),
            .rsp_payload_o  (rsp_pl[g+1])
        );
    end

    // ------------------------------------------------------------------------
    // Stage 3, port switches
    // ------------------------------------------------------------------------
    // Hits always win, responses never stall
    mshr_port_switch #(
        .payload_t (proc_rsp_t),
        .NUM       (N + 1)
    ) u_rsp_switch (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .enable_i  (1'b1),
        .req_i     (rsp_req),
        .payload_i (rsp_pl),
        .grant_o   (rsp_grant),
        .valid_o   (proc_rsp_o),
        .payload_o (rsp_out)
    );

    mshr_port_switch #(
        .payload_t (mem_req_t),
        .NUM       (N)
    ) u_mem_switch (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .enable_i  (mem_enable_i),
        .req_i     (mem_req),
        .payload_i (mem_pl),
        .grant_o   (mem_grant),
        .valid_o   (mem_req_o),
        .payload_o (mem_out)
    );

    // Switch outputs split back into loose ports
    assign proc_rsp_tag_o  = rsp_out.tag;
    assign proc_rsp_data_o = rsp_out.data;
    // Block-aligned byte address
    assign mem_addr_o      = {mem_out.blk, {BLK_OFF_W{1'b0}}};
    assign mem_id_o        = mem_out.id;

endmodule

// File: cache_ctrl_sva.sv
// Port-level rules only; needs the clock running through reset
`timescale 1ns/100ps

module cache_ctrl_sva (
    input logic clk_i,
    input logic reset_i,
    input logic proc_req_i,
    input logic mshr_full_o,
    input logic proc_rsp_o,
    input logic mem_req_o,
    input logic mem_enable_i
);

    // Request leaves the switch one cycle after its grant
    property p_req_after_enable;
        @(posedge clk_i) disable iff (reset_i)
            mem_req_o |-> $past(mem_enable_i);
    endproperty

    // Registered strobes settle after the first reset edge
    property p_quiet_in_reset;
        @(posedge clk_i)
            (reset_i && $past(reset_i)) |-> !(proc_rsp_o || mem_req_o || proc_req_i);
    endproperty

    property p_no_req_when_full;
        @(posedge clk_i) disable iff (reset_i)
            proc_req_i |-> !mshr_full_o;
    endproperty

    a_req_after_enable: assert property (p_req_after_enable)
        else $error("memory request issued while enable was low");
    a_quiet_in_reset: assert property (p_quiet_in_reset)
        else $error("strobe active during reset");
    a_no_req_when_full: assert property (p_no_req_when_full)
        else $error("processor request while MSHRs full");

endmodule

// File: cache_ctrl_tb.sv
// Word-aligned loads only; memory data follows a fixed address rule, run bounded by cycle limits
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cache_ctrl_tb
    import cache_pkg::*;
    import mshr_pkg::*;
();

    localparam int NUM_LOADS   = 2000;
    localparam int NUM_TAGS    = 1 << `CC_TAG_W;
    localparam int NUM_MSHR    = `CC_MSHR_NUM;
    localparam int WORD_BYTES  = `CC_WORD_W / 8;
    localparam int BLK_BYTES   = `CC_BLOCK_WORDS * WORD_BYTES;
    localparam int RUN_LIMIT   = 200000;
    localparam int DRAIN_LIMIT = 5000;

    logic      clk_i;
    logic      reset_i;
    logic      proc_req_i;
    addr_t     proc_addr_i;
    req_tag_t  proc_tag_i;
    logic      mshr_full_o;
    logic      proc_rsp_o;
    req_tag_t  proc_rsp_tag_o;
    word_t     proc_rsp_data_o;
    logic      mem_req_o;
    addr_t     mem_addr_o;
    mshr_idx_t mem_id_o;
    logic      mem_enable_i;
    logic      mem_rsp_i;
    mshr_idx_t mem_rsp_id_i;
    addr_t     mem_rsp_addr_i;
    block_t    mem_rsp_data_i;

    // Scoreboard with one slot per requester tag
    logic  tag_busy  [NUM_TAGS];
    addr_t tag_addr  [NUM_TAGS];
    int    tag_cycle [NUM_TAGS];
    logic  tag_hit   [NUM_TAGS];
    // Model of line contents as block number per line
    logic  line_valid [`CC_LINES];
    int    line_blk   [`CC_LINES];
    // Memory model with one slot per request id
    logic  pend_busy [NUM_MSHR];
    addr_t pend_addr [NUM_MSHR];
    int    pend_due  [NUM_MSHR];
    logic  seen_blk  [(1 << `CC_ADDR_W) / BLK_BYTES];

    int cycle;
    int issued;
    int outstanding;
    int hits;
    int mem_reqs;
    int enable_hold;
    int limit;
    int left;

    cache_ctrl dut (.*);

    bind cache_ctrl cache_ctrl_sva u_sva (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .proc_req_i   (proc_req_i),
        .mshr_full_o  (mshr_full_o),
        .proc_rsp_o   (proc_rsp_o),
        .mem_req_o    (mem_req_o),
        .mem_enable_i (mem_enable_i)
    );

    always #10 clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // Data rule and helpers
    // ------------------------------------------------------------------------
    function automatic word_t word_at(addr_t a);
        logic [31:0] a32;
        a32 = 32'(a);
        return (a32 * 32'h9e37) ^ 32'h5a5a;
    endfunction

    // Word 0 in the low bits
    function automatic block_t block_at(addr_t base);
        block_t b;
        for (int i = 0; i < `CC_BLOCK_WORDS; i++) begin
            b[i] = word_at(base + addr_t'(i * WORD_BYTES));
        end
        return b;
    endfunction

    task automatic fail_run(string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    // ------------------------------------------------------------------------
    // Output monitor sampled 1 ns after the edge
    // ------------------------------------------------------------------------
    task automatic watch_outputs();
        req_tag_t t;
        int       b;
        if (mem_req_o) begin
            b = int'(mem_addr_o) / BLK_BYTES;
            // Enable still holds the value of the grant cycle
            assert (mem_enable_i)
            else fail_run($sformatf("memory request %h issued while enable was low", mem_addr_o));
            assert (int'(mem_addr_o) % BLK_BYTES == 0)
            else fail_run($sformatf("memory request address %h not block-aligned", mem_addr_o));
            assert (!pend_busy[mem_id_o])
            else fail_run($sformatf("memory request id %0d already in flight", mem_id_o));
            for (int i = 0; i < NUM_MSHR; i++) begin
                assert (!(pend_busy[i] && int'(pend_addr[i]) / BLK_BYTES == b))
                else fail_run($sformatf("second memory request for pending block %h", mem_addr_o));
            end
            pend_busy[mem_id_o] = 1'b1;
            pend_addr[mem_id_o] = mem_addr_o;
            pend_due[mem_id_o]  = cycle + 1 + int'($urandom % 40);
            seen_blk[b]         = 1'b1;
            mem_reqs++;
        end
        if (proc_rsp_o) begin
            t = proc_rsp_tag_o;
            assert (tag_busy[t])
            else fail_run($sformatf("response with tag %0d but no load outstanding", t));
            assert (seen_blk[int'(tag_addr[t]) / BLK_BYTES])
            else fail_run("load answered although its block never went to memory");
            assert (proc_rsp_data_o == word_at(tag_addr[t]))
            else fail_run($sformatf("MISMATCH load_data tag %0d: expected %h, actual %h",
                                    t, word_at(tag_addr[t]), proc_rsp_data_o));
            // Known-filled block answers in exactly 2 cycles
            if (tag_hit[t]) begin
                assert (cycle == tag_cycle[t] + 2)
                else fail_run($sformatf("MISMATCH hit_latency tag %0d: expected %0d, actual %0d",
                                        t, 2, cycle - tag_cycle[t]));
            end
            tag_busy[t] = 1'b0;
            outstanding--;
        end
    endtask

    // ------------------------------------------------------------------------
    // Memory model and load stimulus
    // ------------------------------------------------------------------------
    task automatic drive_memory();
        int start;
        int i;
        int b;
        mem_rsp_i = 1'b0;
        // Enable held for random stretches and low about a quarter of the time
        if (enable_hold == 0) begin
            mem_enable_i = ($urandom % 4) != 0;
            enable_hold  = 1 + int'($urandom % 40);
        end else begin
            enable_hold--;
        end
        // Random start slot gives out-of-order answers
        start = int'($urandom % NUM_MSHR);
        for (int k = 0; k < NUM_MSHR; k++) begin
            i = (start + k) % NUM_MSHR;
            if (!mem_rsp_i && pend_busy[i] && pend_due[i] <= cycle) begin
                b              = int'(pend_addr[i]) / BLK_BYTES;
                mem_rsp_i      = 1'b1;
                mem_rsp_id_i   = mshr_idx_t'(i);
                mem_rsp_addr_i = pend_addr[i];
                mem_rsp_data_i = block_at(pend_addr[i]);
                pend_busy[i]   = 1'b0;
                // Fill lands at the next edge
                line_valid[b % `CC_LINES] = 1'b1;
                line_blk[b % `CC_LINES]   = b;
            end
        end
    endtask

    task automatic drive_load(logic allow);
        int    found;
        int    b;
        addr_t a;
        proc_req_i = 1'b0;
        found      = -1;
        if (allow && !mshr_full_o && ($urandom % 8) < 5) begin
            for (int k = 0; k < NUM_TAGS; k++) begin
                if (found < 0 && !tag_busy[k]) begin
                    found = k;
                end
            end
        end
        if (found >= 0) begin
            // 32 blocks over 16 lines give conflicts and secondary misses
            a = addr_t'(($urandom % 32) * BLK_BYTES + ($urandom % `CC_BLOCK_WORDS) * WORD_BYTES);
            b = int'(a) / BLK_BYTES;
            proc_req_i       = 1'b1;
            proc_addr_i      = a;
            proc_tag_i       = req_tag_t'(found);
            tag_busy[found]  = 1'b1;
            tag_addr[found]  = a;
            tag_cycle[found] = cycle;
            tag_hit[found]   = line_valid[b % `CC_LINES] && line_blk[b % `CC_LINES] == b;
            if (tag_hit[found]) begin
                hits++;
            end
            issued++;
            outstanding++;
        end
    endtask

    task automatic step(logic allow);
        @(posedge clk_i);
        cycle++;
        #1;
        watch_outputs();
        drive_memory();
        drive_load(allow);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(32'h647f));
        clk_i          = 1'b0;
        reset_i        = 1'b1;
        proc_req_i     = 1'b0;
        proc_addr_i    = '0;
        proc_tag_i     = '0;
        mem_enable_i   = 1'b0;
        mem_rsp_i      = 1'b0;
        mem_rsp_id_i   = '0;
        mem_rsp_addr_i = '0;
        mem_rsp_data_i = '0;
        cycle          = 0;
        issued         = 0;
        outstanding    = 0;
        hits           = 0;
        mem_reqs       = 0;
        enable_hold    = 0;
        for (int i = 0; i < NUM_TAGS; i++) tag_busy[i] = 1'b0;
        for (int i = 0; i < `CC_LINES; i++) line_valid[i] = 1'b0;
        for (int i = 0; i < NUM_MSHR; i++) pend_busy[i] = 1'b0;
        for (int i = 0; i < $size(seen_blk); i++) seen_blk[i] = 1'b0;

        repeat (16) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        assert (!proc_rsp_o && !mem_req_o && !mshr_full_o)
        else fail_run($sformatf("MISMATCH idle_after_reset: expected 000, actual %b%b%b",
                                proc_rsp_o, mem_req_o, mshr_full_o));

        limit = 0;
        while (issued < NUM_LOADS) begin
            step(1'b1);
            limit++;
            if (limit > RUN_LIMIT) fail_run("timeout while issuing loads");
        end
        // Stimulus stopped while memory keeps answering
        limit = 0;
        while (outstanding != 0) begin
            step(1'b0);
            limit++;
            if (limit > DRAIN_LIMIT) fail_run("timeout while draining outstanding loads");
        end
        step(1'b0);

        left = 0;
        for (int i = 0; i < NUM_MSHR; i++) left += int'(pend_busy[i]);
        if (!mshr_full_o && left == 0) begin
            $display("loads %0d, predicted hits %0d, memory requests %0d", issued, hits, mem_reqs);
            $display("Test OK");
            $finish;
        end else begin
            fail_run("mshr_full_o high or memory requests left after drain");
        end
    end

endmodule

// File: cache_lookup.sv
// Assumes the processor holds off while mshr_full_o is high; no check for a missing free entry
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cache_lookup
    import cache_pkg::*;
    import mshr_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    proc_req_i,
    input  addr_t                   proc_addr_i,
    input  req_tag_t                proc_tag_i,
    output addr_t                   cm_addr_o,
    input  logic                    cm_hit_i,
    input  word_t                   cm_word_i,
    input  mshr_state_e             mshr_state_i [`CC_MSHR_NUM],
    input  blk_addr_t               mshr_blk_i   [`CC_MSHR_NUM],
    output logic [`CC_MSHR_NUM-1:0] alloc_o,
    output addr_t                   req_addr_o,
    output req_tag_t                req_tag_o,
    output logic                    dep_o,
    output mshr_idx_t               dep_idx_o,
    output logic                    hit_rsp_o,
    output proc_rsp_t               hit_payload_o,
    output logic                    mshr_full_o
);

    logic                    req_v_q;
    addr_t                   addr_q;
    req_tag_t                tag_q;
    logic                    miss;
    logic [`CC_MSHR_NUM-1:0] free_vec;

    // ------------------------------------------------------------------------
    // Stage 1 request register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            req_v_q <= 1'b0;
        end else begin
            req_v_q <= proc_req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (proc_req_i) begin
            addr_q <= proc_addr_i;
            tag_q  <= proc_tag_i;
        end
    end

    // Tag check happens in cache_mem
    assign cm_addr_o = addr_q;

    // Hit answers straight away as switch requester 0
    assign hit_rsp_o     = req_v_q && cm_hit_i;
    assign hit_payload_o = '{tag: tag_q, data: cm_word_i};
    assign miss          = req_v_q && !cm_hit_i;

    // ------------------------------------------------------------------------
    // Free entries and allocation
    // ------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < `CC_MSHR_NUM; i++) begin
            free_vec[i] = (mshr_state_i[i] == FREE);
        end
    end

    // Lowest free entry, isolated by two's complement
    assign alloc_o = miss ? (free_vec & (-free_vec)) : '0;

    assign req_addr_o = addr_q;
    assign req_tag_o  = tag_q;

    // Two free slots kept back, one may already sit in stage 1
    assign mshr_full_o = ($countones(free_vec) < 2);

    // ------------------------------------------------------------------------
    // MSHR hit, same block already heading to memory
    // ------------------------------------------------------------------------
    always_comb begin
        dep_o     = 1'b0;
        dep_idx_o = '0;
        // At most one owner per pending block
        for (int i = 0; i < `CC_MSHR_NUM; i++) begin
            if ((mshr_state_i[i] == ISSUE || mshr_state_i[i] == WAIT_MEM) &&
                (mshr_blk_i[i] == blk_of(addr_q))) begin
                dep_o     = 1'b1;
                dep_idx_o = mshr_idx_t'(i);
            end
        end
    end

endmodule

// File: cache_mem.sv
// Read port is combinational; a fill overwrites its line whole, no byte enables
`timescale 1ns/100ps
`include "cache_cfg.svh"

module cache_mem
    import cache_pkg::*;
(
    input  logic   clk_i,
    input  logic   reset_i,
    input  addr_t  rd_addr_i,
    output logic   rd_hit_o,
    output word_t  rd_word_o,
    input  logic   fill_i,
    input  addr_t  fill_addr_i,
    input  block_t fill_data_i
);

    logic [`CC_LINES-1:0] valid_q;
    ctag_t                tag_q  [`CC_LINES];
    block_t               data_q [`CC_LINES];
    line_idx_t            rd_idx;
    logic                 fill_match;

    // ------------------------------------------------------------------------
    // Fill write
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[idx_of(fill_addr_i)] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[idx_of(fill_addr_i)]  <= ctag_of(fill_addr_i);
            data_q[idx_of(fill_addr_i)] <= fill_data_i;
        end
    end

    // ------------------------------------------------------------------------
    // Read with fill bypass
    // ------------------------------------------------------------------------
    assign rd_idx     = idx_of(rd_addr_i);
    // Same block arriving right now
    assign fill_match = fill_i && (blk_of(fill_addr_i) == blk_of(rd_addr_i));

    always_comb begin
        if (fill_match) begin
            rd_hit_o  = 1'b1;
            rd_word_o = fill_data_i[woff_of(rd_addr_i)];
        end else begin
            rd_hit_o  = valid_q[rd_idx] && (tag_q[rd_idx] == ctag_of(rd_addr_i));
            rd_word_o = data_q[rd_idx][woff_of(rd_addr_i)];
        end
    end

endmodule

// File: cache_pkg.sv
// Direct-mapped layout only; address splits into cache tag, line index, word and byte offset
`include "cache_cfg.svh"

package cache_pkg;

    // Field widths of a byte address
    localparam int BYTE_OFF_W = $clog2(`CC_WORD_W / 8);
    localparam int WORD_OFF_W = $clog2(`CC_BLOCK_WORDS);
    localparam int BLK_OFF_W  = WORD_OFF_W + BYTE_OFF_W;
    localparam int IDX_W      = $clog2(`CC_LINES);
    localparam int CTAG_W     = `CC_ADDR_W - IDX_W - BLK_OFF_W;
    localparam int BLK_ADDR_W = `CC_ADDR_W - BLK_OFF_W;

    typedef logic [`CC_ADDR_W-1:0]       addr_t;
    typedef logic [BLK_ADDR_W-1:0]       blk_addr_t;
    typedef logic [`CC_WORD_W-1:0]       word_t;
    // Word 0 sits in the low bits
    typedef word_t [`CC_BLOCK_WORDS-1:0] block_t;
    typedef logic [IDX_W-1:0]            line_idx_t;
    typedef logic [CTAG_W-1:0]           ctag_t;
    typedef logic [WORD_OFF_W-1:0]       woff_t;
    typedef logic [`CC_TAG_W-1:0]        req_tag_t;

    // Load answer toward the processor
    typedef struct packed {
        req_tag_t tag;
        word_t    data;
    } proc_rsp_t;

    // Address field helpers
    function automatic blk_addr_t blk_of(addr_t a);
        return a[`CC_ADDR_W-1:BLK_OFF_W];
    endfunction

    function automatic line_idx_t idx_of(addr_t a);
        return a[BLK_OFF_W +: IDX_W];
    endfunction

    function automatic ctag_t ctag_of(addr_t a);
        return a[`CC_ADDR_W-1 -: CTAG_W];
    endfunction

    function automatic woff_t woff_of(addr_t a);
        return a[BYTE_OFF_W +: WORD_OFF_W];
    endfunction

endpackage

// File: mshr_entry.sv
// One load per entry; a dependent trusts its owner to finish and never times out
`timescale 1ns/100ps
`include "cache_cfg.svh"

module mshr_entry
    import cache_pkg::*;
    import mshr_pkg::*;
#(
    parameter mshr_idx_t ENTRY_IDX = '0
) (
    input  logic                    clk_i,
    input  logic                    reset_i,
    // Allocation from lookup
    input  logic                    alloc_i,
    input  addr_t                   req_addr_i,
    input  req_tag_t                req_tag_i,
    input  logic                    dep_i,
    input  mshr_idx_t               dep_idx_i,
    // Status back to lookup
    output mshr_state_e             state_o,
    output blk_addr_t               blk_o,
    // Memory request switch
    input  logic                    mem_grant_i,
    output logic                    mem_req_o,
    output mem_req_t                mem_payload_o,
    // Memory response
    input  logic                    mem_rsp_i,
    input  mshr_idx_t               mem_rsp_id_i,
    input  block_t                  mem_rsp_data_i,
    // Completion broadcast
    output logic                    cp_flag_o,
    input  logic [`CC_MSHR_NUM-1:0] cp_flags_i,
    // Processor response switch
    input  logic                    rsp_grant_i,
    output logic                    rsp_req_o,
    output proc_rsp_t               rsp_payload_o
);

    mshr_state_e state_q;
    mshr_state_e state_d;
    addr_t       addr_q;
    req_tag_t    tag_q;
    mshr_idx_t   dep_idx_q;
    word_t       word_q;
    logic        own_done;
    logic        dep_done;

    // Own block back from memory
    assign own_done  = (state_q == WAIT_MEM) && mem_rsp_i && (mem_rsp_id_i == ENTRY_IDX);
    // Owner raised its flag, block data is on the shared bus now
    assign dep_done  = (state_q == WAIT_DEP) && cp_flags_i[dep_idx_q];
    assign cp_flag_o = own_done;

    // ------------------------------------------------------------------------
    // Entry FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            FREE: begin
                if (alloc_i) begin
                    state_d = dep_i ? WAIT_DEP : ISSUE;
                end
            end
            ISSUE: begin
                // Grant only comes while memory is enabled
                if (mem_grant_i) begin
                    state_d = WAIT_MEM;
                end
            end
            WAIT_MEM: begin
                if (own_done) begin
                    state_d = DONE;
                end
            end
            WAIT_DEP: begin
                if (dep_done) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                // Hits may keep the port busy for a while
                if (rsp_grant_i) begin
                    state_d = FREE;
                end
            end
            default: state_d = FREE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= FREE;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------------------------------
    // Request and result capture
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (state_q == FREE && alloc_i) begin
            addr_q    <= req_addr_i;
            tag_q     <= req_tag_i;
            dep_idx_q <= dep_idx_i;
        end
        // Owner and dependents pick their word from the same block
        if (own_done || dep_done) begin
            word_q <= mem_rsp_data_i[woff_of(addr_q)];
        end
    end

    assign state_o = state_q;
    assign blk_o   = blk_of(addr_q);

    // Held until granted
    assign mem_req_o     = (state_q == ISSUE);
    assign mem_payload_o = '{blk: blk_of(addr_q), id: ENTRY_IDX};
    assign rsp_req_o     = (state_q == DONE);
    assign rsp_payload_o = '{tag: tag_q, data: word_q};

endmodule

// File: mshr_pkg.sv
// Entry ids double as memory request ids, so memory must echo the id it was given
`include "cache_cfg.svh"

package mshr_pkg;

    import cache_pkg::*;

    typedef logic [$clog2(`CC_MSHR_NUM)-1:0] mshr_idx_t;

    // Entry life cycle
    // Owners go ISSUE then WAIT_MEM, dependents go WAIT_DEP
    typedef enum logic [2:0] {
        FREE,
        ISSUE,
        WAIT_MEM,
        WAIT_DEP,
        DONE
    } mshr_state_e;

    // One block read toward memory
    typedef struct packed {
        blk_addr_t blk;
        mshr_idx_t id;
    } mem_req_t;

endpackage

// File: mshr_port_switch.sv
// Fixed priority, so a steady stream on a low index starves the higher ones
`timescale 1ns/100ps

module mshr_port_switch #(
    parameter type payload_t = logic,
    parameter int  NUM       = 2
) (
    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           enable_i,
    input  logic [NUM-1:0] req_i,
    input  payload_t       payload_i [NUM],
    output logic [NUM-1:0] grant_o,
    output logic           valid_o,
    output payload_t       payload_o
);

    payload_t sel_payload;

    // Lowest requester wins, combinational grant
    assign grant_o = enable_i ? (req_i & (-req_i)) : '0;

    // Payload of the granted requester
    always_comb begin
        sel_payload = payload_i[0];
        for (int i = 0; i < NUM; i++) begin
            if (grant_o[i]) begin
                sel_payload = payload_i[i];
            end
        end
    end

    // ------------------------------------------------------------------------
    // Output register, one cycle after grant
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= |grant_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (|grant_o) begin
            payload_o <= sel_payload;
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module cache_ctrl_tb -o cache_ctrl_sim

./obj_dir/cache_ctrl_sim | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

// File: sim.f
+incdir+.
cache_pkg.sv
mshr_pkg.sv
cache_mem.sv
cache_lookup.sv
mshr_entry.sv
mshr_port_switch.sv
cache_ctrl.sv
cache_ctrl_sva.sv
cache_ctrl_tb.sv
